// File: common/icache_pkg.sv
// ======================================================================
// icache_pkg
// widths, FSM states and bus structs shared by the instruction cache
// ======================================================================

`default_nettype none

package icache_pkg;

    localparam int addr_w   = 32;
    localparam int inst_w   = 32;
    localparam int beat_w   = 64;
    localparam int offset_w = 3;

    // default geometry, 256 sets
    localparam int set_bits = 8;
    localparam int tag_bits = 21;

    // line address, everything above the byte offset
    localparam int line_w = addr_w - offset_w;

    localparam logic [inst_w-1:0] nop_inst  = 32'h0000_0013;
    localparam logic [1:0]        resp_okay = 2'b00;

    typedef enum logic [1:0] {
        idle      = 2'd0,
        request   = 2'd1,
        wait_data = 2'd2,
        drain     = 2'd3
    } fetch_state_e;

    typedef struct packed {
        logic [beat_w-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } r_beat_t;

    // {tag, index} together always form the line address, so the stores
    // re-slice it for any number of sets
    typedef struct packed {
        logic                way;
        logic [set_bits-1:0] index;
        logic [tag_bits-1:0] tag;
    } fill_t;

endpackage

`default_nettype wire

// File: icache/icache_data_store.sv
// ======================================================================
// icache_data_store
// two-way line data array, registered read of both ways and a
// single-way fill write
// ======================================================================

`timescale 1ns/10ps
`default_nettype none

module icache_data_store import icache_pkg::*; #(
    parameter int num_sets = 256
) (
    input  wire logic                       clk,
    input  wire logic [$clog2(num_sets)-1:0] lookup_index,
    input  wire fill_t                      fill,
    input  wire logic                       fill_valid,
    input  wire logic [beat_w-1:0]          fill_data,
    output logic      [1:0][beat_w-1:0]     line_rdata
);

    localparam int idx_w = $clog2(num_sets);

    logic [beat_w-1:0] data_mem [2][num_sets];
    logic [line_w-1:0] fill_line;
    logic [idx_w-1:0]  fill_idx;

    assign fill_line = {fill.tag, fill.index};
    assign fill_idx  = fill_line[idx_w-1:0];

    always_ff @(posedge clk) begin
        if (fill_valid) begin
            data_mem[fill.way][fill_idx] <= fill_data;
        end
    end

    // both ways read every cycle, the controller picks one
    always_ff @(posedge clk) begin
        line_rdata[0] <= data_mem[0][lookup_index];
        line_rdata[1] <= data_mem[1][lookup_index];
    end

endmodule

`default_nettype wire

// File: icache/icache_fetch_ctrl.sv
// ======================================================================
// icache_fetch_ctrl
// miss FSM, AXI read requests, fill commands, instruction output
// and the read error flag
// ======================================================================

`timescale 1ns/10ps
`default_nettype none

module icache_fetch_ctrl import icache_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic [addr_w-1:0]      pc,
    input  wire logic                   stall,
    input  wire logic                   flush,
    input  wire logic                   ar_ready,
    input  wire logic                   r_valid,
    input  wire r_beat_t                r_beat,
    input  wire logic                   hit,
    input  wire logic                   hit_way,
    input  wire logic                   victim_way,
    input  wire logic [1:0][beat_w-1:0] line_rdata,
    output logic      [inst_w-1:0]      inst,
    output logic                        inst_valid,
    output logic                        error,
    output logic                        ar_valid,
    output logic      [addr_w-1:0]      ar_addr,
    output logic                        r_ready,
    output logic                        lookup,
    output logic                        miss_start,
    output fill_t                       fill,
    output logic                        fill_valid,
    output logic      [beat_w-1:0]      fill_data
);

    fetch_state_e      state;
    fetch_state_e      state_next;
    logic              flush_req;
    logic              read_done;
    logic              resp_err;
    logic              beat_take;
    logic              from_cache;
    logic              half_q;
    logic              hit_way_q;
    logic              fill_way_q;
    logic [inst_w-1:0] inst_q;
    logic [beat_w-1:0] cache_line;
    logic [inst_w-1:0] cache_word;
    logic [inst_w-1:0] beat_word;

    assign flush_req  = flush & ~stall;
    assign lookup     = (state == idle) & ~stall & ~flush;
    assign miss_start = lookup & ~hit;

    assign r_ready   = (state == wait_data) | (state == drain);
    assign read_done = r_valid & r_ready & r_beat.last;
    assign resp_err  = r_beat.resp != resp_okay;
    // a beat that meets a flush is dropped like a drained one
    assign beat_take = (state == wait_data) & read_done & ~flush_req;

    // ==================================================================
    // FSM
    // ==================================================================
    always_comb begin
        state_next = state;
        unique case (state)
            idle: begin
                if (miss_start) begin
                    state_next = request;
                end
            end
            request: begin
                if (flush_req) begin
                    // an address accepted on this edge still owes a beat
                    state_next = ar_ready ? drain : idle;
                end else if (ar_ready) begin
                    state_next = wait_data;
                end
            end
            wait_data: begin
                if (read_done) begin
                    state_next = idle;
                end else if (flush_req) begin
                    state_next = drain;
                end
            end
            drain: begin
                if (read_done) begin
                    state_next = idle;
                end
            end
            default: state_next = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    // ==================================================================
    // AXI read address
    // ==================================================================
    always_ff @(posedge clk) begin
        if (rst || flush_req) begin
            ar_valid <= 1'b0;
        end else if (miss_start) begin
            ar_valid <= 1'b1;
        end else if (state == request && ar_ready) begin
            ar_valid <= 1'b0;
        end
    end

    // request address, half select and victim way
    always_ff @(posedge clk) begin
        if (lookup) begin
            half_q    <= pc[2];
            hit_way_q <= hit_way;
        end
        if (miss_start) begin
            ar_addr    <= {pc[addr_w-1:offset_w], {offset_w{1'b0}}};
            fill_way_q <= victim_way;
        end
    end

    // fill goes into the way chosen when the miss started
    assign fill.way                = fill_way_q;
    assign {fill.tag, fill.index}  = ar_addr[addr_w-1:offset_w];
    assign fill_valid              = beat_take & ~resp_err;
    assign fill_data               = r_beat.data;

    // ==================================================================
    // instruction output
    // ==================================================================
    assign cache_line = line_rdata[hit_way_q];
    assign cache_word = half_q ? cache_line[beat_w-1:inst_w] : cache_line[inst_w-1:0];
    assign beat_word  = half_q ? r_beat.data[beat_w-1:inst_w] : r_beat.data[inst_w-1:0];

    // store output is live for one cycle only, then held in inst_q
    assign inst = from_cache ? cache_word : inst_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            from_cache <= 1'b0;
            inst_q     <= nop_inst;
        end else begin
            from_cache <= lookup & hit;
            if (from_cache) begin
                inst_q <= cache_word;
            end else if (beat_take) begin
                inst_q <= resp_err ? nop_inst : beat_word;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush_req) begin
            inst_valid <= 1'b0;
        end else if (lookup) begin
            inst_valid <= hit;
        end else if (beat_take) begin
            inst_valid <= 1'b1;
        end
    end

    // error follows the response of every finished read
    always_ff @(posedge clk) begin
        if (rst) begin
            error <= 1'b0;
        end else if (read_done) begin
            error <= resp_err;
        end
    end

endmodule

`default_nettype wire

// File: icache/icache_tag_store.sv
// ======================================================================
// icache_tag_store
// tags, valid bits and victim bits of a two-way cache, with
// combinational hit detection on the lookup address
// ======================================================================

`timescale 1ns/10ps
`default_nettype none

module icache_tag_store import icache_pkg::*; #(
    parameter int num_sets = 256
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic [addr_w-1:0] lookup_addr,
    input  wire logic              lookup,
    input  wire logic              miss_start,
    input  wire fill_t             fill,
    input  wire logic              fill_valid,
    output logic                   hit,
    output logic                   hit_way,
    output logic                   victim_way
);

    localparam int idx_w = $clog2(num_sets);
    localparam int tag_w = line_w - idx_w;

    logic [tag_w-1:0]  tag_mem [2][num_sets];
    logic [1:0]        valid_q [num_sets];
    logic              victim_q [num_sets];

    logic [idx_w-1:0]  idx;
    logic [tag_w-1:0]  tag;
    logic [line_w-1:0] fill_line;
    logic [idx_w-1:0]  fill_idx;
    logic [tag_w-1:0]  fill_tag;
    logic [1:0]        match;

    assign idx = lookup_addr[offset_w +: idx_w];
    assign tag = lookup_addr[addr_w-1 -: tag_w];

    // re-slice the fill line address for this geometry
    assign fill_line = {fill.tag, fill.index};
    assign fill_idx  = fill_line[idx_w-1:0];
    assign fill_tag  = fill_line[line_w-1:idx_w];

    // ==================================================================
    // lookup
    // ==================================================================
    assign match[0] = valid_q[idx][0] & (tag_mem[0][idx] == tag);
    assign match[1] = valid_q[idx][1] & (tag_mem[1][idx] == tag);

    assign hit     = lookup & (|match);
    assign hit_way = ~match[0];

    // next victim, empty ways first
    always_comb begin
        if (!valid_q[idx][0]) begin
            victim_way = 1'b0;
        end else if (!valid_q[idx][1]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = ~victim_q[idx];
        end
    end

    // ==================================================================
    // update
    // ==================================================================
    always_ff @(posedge clk) begin
        if (fill_valid) begin
            tag_mem[fill.way][fill_idx] <= fill_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_sets; i++) begin
                valid_q[i]  <= 2'b00;
                victim_q[i] <= 1'b0;
            end
        end else begin
            if (miss_start) begin
                victim_q[idx] <= victim_way;
            end
            if (fill_valid) begin
                valid_q[fill_idx][fill.way] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: icache/icache_top.sv
// ======================================================================
// icache_top
// two-way set-associative instruction cache with a single-beat AXI
// read port, built from the fetch controller and the two stores
// ======================================================================

`timescale 1ns/10ps
`default_nettype none

module icache_top import icache_pkg::*; #(
    parameter int num_sets = 256
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic [addr_w-1:0] pc,
    input  wire logic              stall,
    input  wire logic              flush,
    output logic      [inst_w-1:0] inst,
    output logic                   inst_valid,
    output logic                   error,
    output logic                   ar_valid,
    output logic      [addr_w-1:0] ar_addr,
    input  wire logic              ar_ready,
    input  wire logic              r_valid,
    input  wire r_beat_t           r_beat,
    output logic                   r_ready
);

    localparam int idx_w = $clog2(num_sets);

    logic                      lookup;
    logic                      miss_start;
    logic                      hit;
    logic                      hit_way;
    logic                      victim_way;
    fill_t                     fill;
    logic                      fill_valid;
    logic [beat_w-1:0]         fill_data;
    logic [1:0][beat_w-1:0]    line_rdata;

    icache_fetch_ctrl icache_fetch_ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .stall      (stall),
        .flush      (flush),
        .ar_ready   (ar_ready),
        .r_valid    (r_valid),
        .r_beat     (r_beat),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .line_rdata (line_rdata),
        .inst       (inst),
        .inst_valid (inst_valid),
        .error      (error),
        .ar_valid   (ar_valid),
        .ar_addr    (ar_addr),
        .r_ready    (r_ready),
        .lookup     (lookup),
        .miss_start (miss_start),
        .fill       (fill),
        .fill_valid (fill_valid),
        .fill_data  (fill_data)
    );

    icache_tag_store #(
        .num_sets (num_sets)
    ) icache_tag_store_i (
        .clk         (clk),
        .rst         (rst),
        .lookup_addr (pc),
        .lookup      (lookup),
        .miss_start  (miss_start),
        .fill        (fill),
        .fill_valid  (fill_valid),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_way  (victim_way)
    );

    icache_data_store #(
        .num_sets (num_sets)
    ) icache_data_store_i (
        .clk          (clk),
        .lookup_index (pc[offset_w +: idx_w]),
        .fill         (fill),
        .fill_valid   (fill_valid),
        .fill_data    (fill_data),
        .line_rdata   (line_rdata)
    );

endmodule

`default_nettype wire

// File: project.f
common/icache_pkg.sv
icache/icache_data_store.sv
icache/icache_tag_store.sv
icache/icache_fetch_ctrl.sv
icache/icache_top.sv
verification/icache_tb_mem.sv
verification/icache_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary --timing -j 0 --top-module icache_tb \
    -Mdir "$obj" -o icache_sim -f project.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$obj/icache_sim" > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$log"; then
    echo "simulation reported failure"
    exit 1
fi

if ! grep -q "TEST RESULT: PASS" "$log"; then
    echo "no result line found in $log"
    exit 1
fi

exit 0

// File: verification/icache_tb.sv
// ======================================================================
// icache_tb
// table driven testbench for the instruction cache, with a reference
// model of tags, valid bits and victim bits
// ======================================================================

`timescale 1ns/10ps
`default_nettype none

module icache_tb import icache_pkg::*; ();

    localparam int num_sets = 256;
    localparam int idx_w    = $clog2(num_sets);
    localparam int period   = 40;
    localparam int n_tests  = 20;
    localparam logic [31:0] nop_word = 32'h0000_0013;

    typedef enum logic [1:0] {act_none, act_stall, act_flush_req, act_flush_wait} action_e;

    typedef struct {
        string       name;
        logic [31:0] pc;
        action_e     act;
        logic [31:0] exp_inst;
        bit          exp_hit;
        bit          exp_err;
    } test_t;

    logic              clk;
    logic              rst;
    logic [addr_w-1:0] pc;
    logic              stall;
    logic              flush;
    logic [inst_w-1:0] inst;
    logic              inst_valid;
    logic              error;
    logic              ar_valid;
    logic [addr_w-1:0] ar_addr;
    logic              ar_ready;
    logic              r_valid;
    r_beat_t           r_beat;
    logic              r_ready;

    test_t       tbl [n_tests];
    int          n_added;
    int          mismatches;
    bit          model_valid [2][num_sets];
    logic [31:0] model_tag [2][num_sets];
    bit          model_victim [num_sets];

    icache_top #(
        .num_sets (num_sets)
    ) icache_top_i (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .stall      (stall),
        .flush      (flush),
        .inst       (inst),
        .inst_valid (inst_valid),
        .error      (error),
        .ar_valid   (ar_valid),
        .ar_addr    (ar_addr),
        .ar_ready   (ar_ready),
        .r_valid    (r_valid),
        .r_beat     (r_beat),
        .r_ready    (r_ready)
    );

    icache_tb_mem #(
        .err_lo (32'h0000_8000),
        .err_hi (32'h0000_8fff)
    ) icache_tb_mem_i (
        .clk      (clk),
        .rst      (rst),
        .ar_valid (ar_valid),
        .ar_addr  (ar_addr),
        .ar_ready (ar_ready),
        .r_valid  (r_valid),
        .r_beat   (r_beat),
        .r_ready  (r_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // ==================================================================
    // reference model
    // ==================================================================
    function automatic logic [31:0] word_at(input logic [31:0] a);
        return {a[31:2], 2'b00} ^ 32'h5a5a_0000;
    endfunction

    function automatic bit predict_hit(input logic [31:0] a);
        int          idx;
        logic [31:0] tg;
        idx = int'((a >> 3) % num_sets);
        tg  = a >> (3 + idx_w);
        return (model_valid[0][idx] && model_tag[0][idx] == tg) ||
               (model_valid[1][idx] && model_tag[1][idx] == tg);
    endfunction

    // empty ways first, else flip the set's victim bit
    function automatic bit start_miss(input logic [31:0] a);
        int idx;
        bit way;
        idx = int'((a >> 3) % num_sets);
        if (!model_valid[0][idx]) begin
            way = 1'b0;
        end else if (!model_valid[1][idx]) begin
            way = 1'b1;
        end else begin
            way = !model_victim[idx];
        end
        model_victim[idx] = way;
        return way;
    endfunction

    function automatic void fill_model(input logic [31:0] a, input bit way);
        int idx;
        idx = int'((a >> 3) % num_sets);
        model_valid[way][idx] = 1'b1;
        model_tag[way][idx]   = a >> (3 + idx_w);
    endfunction

    // ==================================================================
    // stimulus table
    // ==================================================================
    task automatic add_test(input string name, input logic [31:0] a, input action_e act,
                            input bit hit, input bit err, input logic [31:0] exp_inst);
        tbl[n_added].name     = name;
        tbl[n_added].pc       = a;
        tbl[n_added].act      = act;
        tbl[n_added].exp_inst = exp_inst;
        tbl[n_added].exp_hit  = hit;
        tbl[n_added].exp_err  = err;
        n_added++;
    endtask

    task automatic build_table();
        add_test("cold_lo", 32'h0100, act_none, 0, 0, word_at(32'h0100));
        add_test("cold_hi", 32'h0104, act_none, 1, 0, word_at(32'h0104));
        add_test("reuse_lo", 32'h0100, act_none, 1, 0, word_at(32'h0100));
        add_test("same_set_b", 32'h0900, act_none, 0, 0, word_at(32'h0900));
        add_test("resident_a", 32'h0104, act_none, 1, 0, word_at(32'h0104));
        add_test("resident_b", 32'h0904, act_none, 1, 0, word_at(32'h0904));
        add_test("third_tag", 32'h1100, act_none, 0, 0, word_at(32'h1100));
        add_test("evicted_a", 32'h0100, act_none, 0, 0, word_at(32'h0100));
        add_test("kept_c", 32'h1104, act_none, 1, 0, word_at(32'h1104));
        add_test("evicted_b", 32'h0900, act_none, 0, 0, word_at(32'h0900));
        add_test("kept_a", 32'h0104, act_none, 1, 0, word_at(32'h0104));
        // inst still shows kept_a while stalled
        add_test("stall_hold", 32'h2000, act_stall, 1, 0, word_at(32'h0104));
        add_test("flush_req", 32'h3000, act_flush_req, 0, 0, word_at(32'h3000));
        add_test("after_flush_req", 32'h3000, act_none, 0, 0, word_at(32'h3000));
        add_test("flush_wait", 32'h4008, act_flush_wait, 0, 0, word_at(32'h4008));
        add_test("after_flush_wait", 32'h4008, act_none, 0, 0, word_at(32'h4008));
        add_test("err_read", 32'h8014, act_none, 0, 1, nop_word);
        // an error response leaves the line empty
        add_test("err_again", 32'h8010, act_none, 0, 1, nop_word);
        add_test("good_read", 32'h500c, act_none, 0, 0, word_at(32'h500c));
        add_test("good_hit", 32'h5008, act_none, 1, 0, word_at(32'h5008));
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Mismatch in %s: expected %h, actual %h", what, exp, act);
        mismatches++;
    endtask

    // ==================================================================
    // apply one entry, starting and ending on a falling edge
    // ==================================================================
    task automatic run_test(input int i);
        test_t t;
        bit    exp_model;
        bit    got_hit;
        bit    way;
        t         = tbl[i];
        exp_model = predict_hit(t.pc);
        pc        = t.pc;
        if (t.act == act_stall) begin
            repeat (4) begin
                @(negedge clk);
                if (ar_valid !== 1'b0) report_mismatch({t.name, " ar_valid"}, 0, 32'(ar_valid));
                if (inst_valid !== t.exp_hit)
                    report_mismatch({t.name, " inst_valid"}, 32'(t.exp_hit), 32'(inst_valid));
                if (inst !== t.exp_inst) report_mismatch({t.name, " inst"}, t.exp_inst, inst);
            end
        end else begin
            stall = 1'b0;
            @(negedge clk);
            got_hit = inst_valid;
            stall   = 1'b1;
            if (got_hit !== t.exp_hit)
                report_mismatch({t.name, " hit"}, 32'(t.exp_hit), 32'(got_hit));
            if (got_hit !== exp_model)
                report_mismatch({t.name, " model hit"}, 32'(exp_model), 32'(got_hit));
            if (got_hit) begin
                if (ar_valid !== 1'b0) report_mismatch({t.name, " ar_valid"}, 0, 32'(ar_valid));
                if (inst !== t.exp_inst) report_mismatch({t.name, " inst"}, t.exp_inst, inst);
                if (error !== t.exp_err)
                    report_mismatch({t.name, " error"}, 32'(t.exp_err), 32'(error));
            end else begin
                way = start_miss(t.pc);
                if (ar_valid !== 1'b1) report_mismatch({t.name, " ar_valid"}, 1, 32'(ar_valid));
                if (ar_addr !== (t.pc & ~32'h7))
                    report_mismatch({t.name, " ar_addr"}, t.pc & ~32'h7, ar_addr);
                if (t.act == act_none) begin
                    while (inst_valid !== 1'b1) @(negedge clk);
                    if (inst !== t.exp_inst) report_mismatch({t.name, " inst"}, t.exp_inst, inst);
                    if (error !== t.exp_err)
                        report_mismatch({t.name, " error"}, 32'(t.exp_err), 32'(error));
                    if (!t.exp_err) fill_model(t.pc, way);
                end else begin
                    if (t.act == act_flush_wait) begin
                        while (r_ready !== 1'b1) @(negedge clk);
                    end
                    flush = 1'b1;
                    stall = 1'b0;
                    @(negedge clk);
                    flush = 1'b0;
                    stall = 1'b1;
                    if (ar_valid !== 1'b0)
                        report_mismatch({t.name, " ar_valid"}, 0, 32'(ar_valid));
                    // drain keeps taking the outstanding beat
                    if (t.act == act_flush_wait && r_ready !== 1'b1)
                        report_mismatch({t.name, " r_ready"}, 1, 32'(r_ready));
                    // drained beat must be gone before the next lookup
                    while (r_ready !== 1'b0) @(negedge clk);
                    if (inst_valid !== 1'b0)
                        report_mismatch({t.name, " inst_valid"}, 0, 32'(inst_valid));
                end
            end
        end
    endtask

    // ==================================================================
    // main sequence and watchdog
    // ==================================================================
    initial begin
        rst        = 1'b1;
        stall      = 1'b1;
        flush      = 1'b0;
        pc         = '0;
        n_added    = 0;
        mismatches = 0;
        for (int s = 0; s < num_sets; s++) begin
            model_valid[0][s] = 1'b0;
            model_valid[1][s] = 1'b0;
            model_victim[s]   = 1'b0;
        end
        build_table();
        repeat (10) @(negedge clk);
        rst = 1'b0;
        if (inst_valid !== 1'b0) report_mismatch("reset inst_valid", 0, 32'(inst_valid));
        if (ar_valid !== 1'b0) report_mismatch("reset ar_valid", 0, 32'(ar_valid));
        if (r_ready !== 1'b0) report_mismatch("reset r_ready", 0, 32'(r_ready));
        if (error !== 1'b0) report_mismatch("reset error", 0, 32'(error));
        if (inst !== nop_word) report_mismatch("reset inst", nop_word, inst);
        for (int i = 0; i < n_tests; i++) begin
            run_test(i);
        end
        $display("checks done: %0d mismatches, 0 other errors", mismatches);
        if (mismatches == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #((10 + n_tests * 20) * period);
        $display("Error: watchdog expired before the stimulus table finished");
        $display("checks stopped: %0d mismatches, 1 other errors", mismatches);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/icache_tb_mem.sv
// ======================================================================
// icache_tb_mem
// AXI read memory model for the instruction cache testbench, with a
// random response delay and an error address window
// ======================================================================

`timescale 1ns/10ps
`default_nettype none

module icache_tb_mem import icache_pkg::*; #(
    parameter logic [addr_w-1:0] err_lo = 32'h0000_8000,
    parameter logic [addr_w-1:0] err_hi = 32'h0000_8fff
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              ar_valid,
    input  wire logic [addr_w-1:0] ar_addr,
    output logic                   ar_ready,
    output logic                   r_valid,
    output r_beat_t                r_beat,
    input  wire logic              r_ready
);

    integer            seed = 32'hcd956927;
    logic              ar_seen;
    logic              r_ready_q;
    logic              busy;
    logic [1:0]        wait_cnt;
    logic [addr_w-1:0] addr_q;

    // each word is its byte address xor a fixed pattern
    function automatic logic [beat_w-1:0] beat_at(input logic [addr_w-1:0] a);
        logic [addr_w-1:0] base;
        base = {a[addr_w-1:3], 3'b000};
        return {(base + 32'd4) ^ 32'h5a5a_0000, base ^ 32'h5a5a_0000};
    endfunction

    // outputs change on the falling edge, transfers happen on the rising edge
    always @(negedge clk) begin
        r_ready_q <= r_ready;
        if (rst) begin
            ar_ready <= 1'b0;
            ar_seen  <= 1'b0;
            r_valid  <= 1'b0;
            busy     <= 1'b0;
            wait_cnt <= 2'd0;
            r_beat   <= '0;
        end else begin
            // ready on the second falling edge that sees ar_valid
            if (ar_ready) begin
                ar_ready <= 1'b0;
                ar_seen  <= 1'b0;
                busy     <= 1'b1;
                wait_cnt <= 2'($unsigned($random(seed)) % 4);
            end else if (ar_valid && !busy) begin
                ar_ready <= ar_seen;
                ar_seen  <= 1'b1;
                addr_q   <= ar_addr;
            end else begin
                ar_seen <= 1'b0;
            end
            // read beat
            if (r_valid && r_ready_q) begin
                r_valid <= 1'b0;
                busy    <= 1'b0;
            end else if (busy && !r_valid) begin
                if (wait_cnt == 2'd0) begin
                    r_valid     <= 1'b1;
                    r_beat.data <= beat_at(addr_q);
                    r_beat.resp <= (addr_q >= err_lo && addr_q <= err_hi) ? 2'b10 : resp_okay;
                    r_beat.last <= 1'b1;
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire
